// File: testbench/uart_regs_stimulus.txt
# op arg1 arg2 in hex: W adr data, R adr expected, P pins rx_d, I cycles, Q irq, M modem_n, B
# pins: 10 ri_n 9 dcd_n 8 dsr_n 7 cts_n 6 tx_sr_empty 5 tx_empty 4 oe 3 bi 2 fe 1 pe 0 rx_empty
P 7E1 00
Q 0
R 3 00
R 1 00
R 4 00
R 5 60
R 6 00
M F
# scratch, LCR, IER, MCR read-back
W 7 A5
R 7 A5
W 3 1B
R 3 1B
W 1 FF
R 1 0F
W 4 F3
R 4 03
R 2 00
# divisor latch under DLAB
W 3 80
W 0 07
W 1 00
R 0 07
R 1 00
I 4
B
W 3 03
R 1 0F
R 3 03
W 0 55
P 7E1 C3
R 0 C3
# second divisor
W 3 83
W 0 0C
I 4
B
W 3 03
# modem outputs, loop bit is masked off
W 4 05
M A
W 4 0A
M 5
W 4 1F
R 4 0F
R 6 00
W 4 00
M F
P 761 00
I 2
R 6 11
R 6 10
P 7E1 00
I 2
R 6 01
R 6 00
# line status
P 7E3 00
P 7E1 00
I 3
R 5 64
R 5 60
P 7E0 00
I 1
R 5 61
P 7A0 00
I 1
R 5 21
P 781 00
I 1
R 5 00
P 7E1 00
# receive interrupt
W 1 01
Q 0
P 7E0 00
Q 1
W 1 00
Q 0
P 7E1 00
R 5 60

// File: verilog.f
+incdir+verilog
verilog/uart_regs_pkg.sv
verilog/uart_line_status.sv
verilog/uart_modem_status.sv
verilog/uart_baud_gen.sv
verilog/uart_host_regs.sv
verilog/uart_regs_top.sv
testbench/tb_clk_gen.sv
testbench/tb_checker.sv
testbench/tb_uart_regs.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the UART register block testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f verilog.f --top-module tb_uart_regs -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_uart_regs)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

// File: testbench/tb_uart_regs.sv
/*
 * UART register block testbench
 * Replays the stimulus file on the host bus and pins, tracks DLAB
 * and the divisor latch, hands expected values to the checker
 */
module tb_uart_regs;

  timeunit 1ns;
  timeprecision 100ps;

  import uart_regs_pkg::*;

  logic       clk;
  logic       rst_n;
  adr_t       adr;
  data_t      d;
  logic       we;
  logic       re;
  data_t      q;
  data_t      rx_d;
  logic       rx_empty;
  logic       rx_pe;
  logic       rx_fe;
  logic       rx_bi;
  logic       overrun;
  logic       tx_empty;
  logic       tx_sr_empty;
  logic       cts_n;
  logic       dsr_n;
  logic       dcd_n;
  logic       ri_n;
  logic       rts_n;
  logic       dtr_n;
  logic       out1_n;
  logic       out2_n;
  logic       tx_push;
  logic       rx_pop;
  logic       irq;
  logic       baudout;

  // Toward the checker
  data_t      exp_q;
  logic       exp_push;
  logic       exp_pop;
  logic       wait_req;
  logic [1:0] wait_kind;
  int         wait_arg;
  int         wait_count;
  int         value_errs;
  int         timeout_errs;
  int         tb_errs;

  // Host view of DLAB and the divisor latch
  logic       dlab;
  data_t      dll;
  data_t      dlm;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_regs_top u_uart_regs_top (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .adr_i           (adr),
    .d_i             (d),
    .we_i            (we),
    .re_i            (re),
    .q_o             (q),
    .rx_d_i          (rx_d),
    .rx_empty_i      (rx_empty),
    .rx_pe_i         (rx_pe),
    .rx_fe_i         (rx_fe),
    .rx_bi_i         (rx_bi),
    .overrun_error_i (overrun),
    .tx_empty_i      (tx_empty),
    .tx_sr_empty_i   (tx_sr_empty),
    .cts_ni          (cts_n),
    .dsr_ni          (dsr_n),
    .dcd_ni          (dcd_n),
    .ri_ni           (ri_n),
    .rts_no          (rts_n),
    .dtr_no          (dtr_n),
    .out1_no         (out1_n),
    .out2_no         (out2_n),
    .tx_push_o       (tx_push),
    .rx_pop_o        (rx_pop),
    .irq_o           (irq),
    .baudout_o       (baudout)
  );

  tb_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .re_i           (re),
    .q_i            (q),
    .exp_q_i        (exp_q),
    .tx_push_i      (tx_push),
    .rx_pop_i       (rx_pop),
    .exp_push_i     (exp_push),
    .exp_pop_i      (exp_pop),
    .modem_n_i      ({out2_n, out1_n, rts_n, dtr_n}),
    .irq_i          (irq),
    .baudout_i      (baudout),
    .wait_req_i     (wait_req),
    .wait_kind_i    (wait_kind),
    .wait_arg_i     (wait_arg),
    .wait_count_o   (wait_count),
    .value_errs_o   (value_errs),
    .timeout_errs_o (timeout_errs)
  );

  //////////////////////////////
  // Bus and pin drivers
  //////////////////////////////

  // One write strobe, THR push only with DLAB clear
  task automatic write_reg(input adr_t a, input data_t v);
    @(posedge clk);
    adr      <= a;
    d        <= v;
    we       <= 1'b1;
    exp_push <= (a == 3'd0) && !dlab;
    @(posedge clk);
    we       <= 1'b0;
    exp_push <= 1'b0;
    // DLL at 0, DLM at 1 under DLAB
    if (dlab && a == 3'd0)
      dll = v;
    if (dlab && a == 3'd1)
      dlm = v;
    if (a == 3'd3)
      dlab = v[7];
  endtask

  // One read strobe, checker compares a cycle later
  task automatic read_reg(input adr_t a, input data_t exp);
    @(posedge clk);
    adr     <= a;
    re      <= 1'b1;
    exp_q   <= exp;
    exp_pop <= (a == 3'd0) && !dlab;
    @(posedge clk);
    re      <= 1'b0;
    exp_pop <= 1'b0;
  endtask

  // Bit order as in the stimulus file header
  task automatic set_pins(input int pins, input int rxd);
    @(posedge clk);
    rx_empty    <= pins[0];
    rx_pe       <= pins[1];
    rx_fe       <= pins[2];
    rx_bi       <= pins[3];
    overrun     <= pins[4];
    tx_empty    <= pins[5];
    tx_sr_empty <= pins[6];
    cts_n       <= pins[7];
    dsr_n       <= pins[8];
    dcd_n       <= pins[9];
    ri_n        <= pins[10];
    rx_d        <= rxd[7:0];
  endtask

  // Hand a check to the checker and wait for its answer
  task automatic request_check(input logic [1:0] kind, input int arg);
    int start;
    int n;
    @(posedge clk);
    start     = wait_count;
    wait_kind <= kind;
    wait_arg  <= arg;
    wait_req  <= 1'b1;
    @(posedge clk);
    wait_req  <= 1'b0;
    n = 0;
    while (wait_count == start && n < 4000)
    begin
      @(posedge clk);
      n++;
    end
    if (wait_count == start)
    begin
      $display("Checker gave no answer within 4000 cycles for check kind %0d", kind);
      tb_errs++;
    end
  endtask

  //////////////////////////////
  // Stimulus replay
  //////////////////////////////

  initial
  begin : replay
    int    fd;
    int    n;
    int    a;
    int    b;
    byte   op;
    string line;

    adr         <= '0;
    d           <= '0;
    we          <= 1'b0;
    re          <= 1'b0;
    rx_d        <= '0;
    rx_empty    <= 1'b1;
    rx_pe       <= 1'b0;
    rx_fe       <= 1'b0;
    rx_bi       <= 1'b0;
    overrun     <= 1'b0;
    tx_empty    <= 1'b1;
    tx_sr_empty <= 1'b1;
    cts_n       <= 1'b1;
    dsr_n       <= 1'b1;
    dcd_n       <= 1'b1;
    ri_n        <= 1'b1;
    exp_q       <= '0;
    exp_push    <= 1'b0;
    exp_pop     <= 1'b0;
    wait_req    <= 1'b0;
    wait_kind   <= 2'd0;
    wait_arg    <= 0;
    dlab        = 1'b0;
    dll         = '0;
    dlm         = '0;
    tb_errs     = 0;

    n = 0;
    while (rst_n !== 1'b1 && n < 40)
    begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("Reset was not released within 40 cycles");
      tb_errs++;
    end

    fd = $fopen("testbench/uart_regs_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open testbench/uart_regs_stimulus.txt");
      tb_errs++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() < 2 || line.getc(0) == "#")
          continue;
        op = line.getc(0);
        a  = 0;
        b  = 0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
        case (op)
          "W": write_reg(adr_t'(a), data_t'(b));
          "R": read_reg(adr_t'(a), data_t'(b));
          "P": set_pins(a, b);
          "I": repeat (a) @(posedge clk);
          "Q": request_check(2'd2, a);
          "M": request_check(2'd3, a);
          // Period is divisor + 1
          "B": request_check(2'd1, int'({dlm, dll}) + 1);
          default:
          begin
            $display("Unknown operation in stimulus line: %s", line);
            tb_errs++;
          end
        endcase
      end
      $fclose(fd);
    end

    // Last read reaches the checker
    repeat (3) @(posedge clk);
    $display("Errors: %0d value, %0d timeout, %0d testbench", value_errs, timeout_errs,
             tb_errs);
    if (value_errs == 0 && timeout_errs == 0 && tb_errs == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: testbench/tb_checker.sv
/*
 * Testbench checker
 * Compares read data, FIFO strobes and modem pins, times baud pulses
 * and waits for irq levels on request
 */
module tb_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  re_i,
  input  uart_regs_pkg::data_t  q_i,
  input  uart_regs_pkg::data_t  exp_q_i,
  input  logic                  tx_push_i,
  input  logic                  rx_pop_i,
  input  logic                  exp_push_i,
  input  logic                  exp_pop_i,
  input  logic [3:0]            modem_n_i,
  input  logic                  irq_i,
  input  logic                  baudout_i,
  input  logic                  wait_req_i,
  input  logic [1:0]            wait_kind_i,
  input  int                    wait_arg_i,
  output int                    wait_count_o,
  output int                    value_errs_o,
  output int                    timeout_errs_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import uart_regs_pkg::*;

  int    read_errs = 0;
  int    wait_errs = 0;
  int    timeouts = 0;
  int    done_cnt = 0;
  logic  pend = 1'b0;
  data_t exp_hold = '0;

  assign value_errs_o   = read_errs + wait_errs;
  assign timeout_errs_o = timeouts;
  assign wait_count_o   = done_cnt;

  //////////////////////////////
  // Per-cycle compares
  //////////////////////////////

  // Negedge sampling, inputs settled
  always @(negedge clk_i)
  begin
    if (!rst_ni)
      pend = 1'b0;
    else
    begin
      // Read data lands one cycle after re_i
      if (pend && q_i !== exp_hold)
      begin
        $display("[FAIL] %0t ns: read data %02h, expected %02h", $time, q_i, exp_hold);
        read_errs++;
      end
      pend     = re_i;
      exp_hold = exp_q_i;
      if (tx_push_i !== exp_push_i)
      begin
        $display("[FAIL] %0t ns: tx_push_o is %0b, expected %0b", $time, tx_push_i,
                 exp_push_i);
        read_errs++;
      end
      if (rx_pop_i !== exp_pop_i)
      begin
        $display("[FAIL] %0t ns: rx_pop_o is %0b, expected %0b", $time, rx_pop_i,
                 exp_pop_i);
        read_errs++;
      end
    end
  end

  //////////////////////////////
  // Requested checks
  //////////////////////////////

  // Skip to a pulse, then time two full intervals
  task automatic measure_baud(input int period);
    int n;
    int k;
    int limit;
    limit = 4 * period + 16;
    n = 0;
    while (!baudout_i && n < limit)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!baudout_i)
    begin
      $display("Timeout: no baudout_o pulse within %0d cycles", limit);
      timeouts++;
      return;
    end
    for (k = 0; k < 2; k++)
    begin
      n = 0;
      do
      begin
        @(negedge clk_i);
        n++;
      end
      while (!baudout_i && n < limit);
      if (!baudout_i)
      begin
        $display("Timeout: baudout_o stopped pulsing after %0d cycles", limit);
        timeouts++;
        return;
      end
      if (n != period)
      begin
        $display("[FAIL] %0t ns: baud interval %0d cycles, expected %0d", $time, n, period);
        wait_errs++;
      end
    end
  endtask

  // irq_o is registered, a few cycles are enough
  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq_i !== level && n < 8)
    begin
      @(negedge clk_i);
      n++;
    end
    if (irq_i !== level)
    begin
      $display("Timeout: irq_o did not reach %0b within 8 cycles", level);
      timeouts++;
    end
  endtask

  // Order out2_n, out1_n, rts_n, dtr_n
  task automatic compare_modem(input logic [3:0] exp);
    if (modem_n_i !== exp)
    begin
      $display("[FAIL] %0t ns: modem outputs %04b, expected %04b", $time, modem_n_i, exp);
      wait_errs++;
    end
  endtask

  // 1 baud, 2 irq level, 3 modem outputs
  always @(negedge clk_i)
  begin
    if (rst_ni && wait_req_i)
    begin
      case (wait_kind_i)
        2'd1: measure_baud(wait_arg_i);
        2'd2: wait_irq(wait_arg_i[0]);
        default: compare_modem(wait_arg_i[3:0]);
      endcase
      done_cnt++;
    end
  end

endmodule

// File: testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 40 ns clock, active low reset held for 10 cycles
 */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, 20 ns half period
  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release on a rising edge after 10 cycles
  initial
  begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: verilog/uart_regs_top.sv
/*
 * UART 16550 register block
 * Host registers, line and modem status encoders, baud generator
 */
module uart_regs_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Host bus
  input  uart_regs_pkg::adr_t   adr_i,
  input  uart_regs_pkg::data_t  d_i,
  input  logic                  we_i,
  input  logic                  re_i,
  output uart_regs_pkg::data_t  q_o,
  // Receive and transmit FIFO status
  input  uart_regs_pkg::data_t  rx_d_i,
  input  logic                  rx_empty_i,
  input  logic                  rx_pe_i,
  input  logic                  rx_fe_i,
  input  logic                  rx_bi_i,
  input  logic                  overrun_error_i,
  input  logic                  tx_empty_i,
  input  logic                  tx_sr_empty_i,
  // Modem pins, active low
  input  logic                  cts_ni,
  input  logic                  dsr_ni,
  input  logic                  dcd_ni,
  input  logic                  ri_ni,
  output logic                  rts_no,
  output logic                  dtr_no,
  output logic                  out1_no,
  output logic                  out2_no,
  // FIFO strobes, interrupt, baud enable
  output logic                  tx_push_o,
  output logic                  rx_pop_o,
  output logic                  irq_o,
  output logic                  baudout_o
);

  import uart_regs_pkg::*;

  data_t    lsr;
  data_t    msr;
  logic     lsr_read;
  logic     msr_read;
  mcr_ctl_t mcr_ctl;
  logic     loop_en;
  divisor_t divisor;
  logic     div_load;

  //////////////////////////////
  // Host side
  //////////////////////////////

  uart_host_regs u_host_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .adr_i      (adr_i),
    .d_i        (d_i),
    .we_i       (we_i),
    .re_i       (re_i),
    .q_o        (q_o),
    .rx_d_i     (rx_d_i),
    .lsr_i      (lsr),
    .msr_i      (msr),
    .tx_push_o  (tx_push_o),
    .rx_pop_o   (rx_pop_o),
    .lsr_read_o (lsr_read),
    .msr_read_o (msr_read),
    .mcr_ctl_o  (mcr_ctl),
    .loop_en_o  (loop_en),
    .divisor_o  (divisor),
    .div_load_o (div_load),
    .rts_no     (rts_no),
    .dtr_no     (dtr_no),
    .out1_no    (out1_no),
    .out2_no    (out2_no),
    .irq_o      (irq_o)
  );

  //////////////////////////////
  // Status and baud
  //////////////////////////////

  uart_line_status u_line_status (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_empty_i      (rx_empty_i),
    .rx_pe_i         (rx_pe_i),
    .rx_fe_i         (rx_fe_i),
    .rx_bi_i         (rx_bi_i),
    .overrun_error_i (overrun_error_i),
    .tx_empty_i      (tx_empty_i),
    .tx_sr_empty_i   (tx_sr_empty_i),
    .lsr_read_i      (lsr_read),
    .lsr_o           (lsr)
  );

  uart_modem_status u_modem_status (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cts_ni     (cts_ni),
    .dsr_ni     (dsr_ni),
    .dcd_ni     (dcd_ni),
    .ri_ni      (ri_ni),
    .mcr_ctl_i  (mcr_ctl),
    .loop_en_i  (loop_en),
    .msr_read_i (msr_read),
    .msr_o      (msr)
  );

  uart_baud_gen u_baud_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .divisor_i  (divisor),
    .div_load_i (div_load),
    .baudout_o  (baudout_o)
  );

endmodule

// File: verilog/uart_host_regs.sv
/*
 * UART host register file
 * Holds IER, LCR, MCR, SCR and the divisor latch, muxes read data,
 * generates FIFO and status read strobes, modem outputs and the interrupt
 */
`include "uart_regs_cfg.svh"

module uart_host_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  uart_regs_pkg::adr_t      adr_i,
  input  uart_regs_pkg::data_t     d_i,
  input  logic                     we_i,
  input  logic                     re_i,
  output uart_regs_pkg::data_t     q_o,
  input  uart_regs_pkg::data_t     rx_d_i,
  input  uart_regs_pkg::data_t     lsr_i,
  input  uart_regs_pkg::data_t     msr_i,
  output logic                     tx_push_o,
  output logic                     rx_pop_o,
  output logic                     lsr_read_o,
  output logic                     msr_read_o,
  output uart_regs_pkg::mcr_ctl_t  mcr_ctl_o,
  output logic                     loop_en_o,
  output uart_regs_pkg::divisor_t  divisor_o,
  output logic                     div_load_o,
  output logic                     rts_no,
  output logic                     dtr_no,
  output logic                     out1_no,
  output logic                     out2_no,
  output logic                     irq_o
);

  import uart_regs_pkg::*;

  data_t ier;
  data_t lcr;
  data_t mcr;
  data_t scr;
  data_t dll;
  data_t dlm;
  logic  dlab;

  assign dlab = lcr[`UART_LCR_DLAB_BIT];

  //////////////////////////////
  // Register writes
  //////////////////////////////

  // Control registers, IER and MCR masked to the low nibble
  // IER is hidden behind DLM while DLAB is set
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ier <= '0;
      lcr <= '0;
      mcr <= '0;
      scr <= '0;
    end
    else if (we_i)
    begin
      if (adr_i == `UART_IER_ADR && !dlab)
        ier <= d_i & `UART_LOW_NIBBLE_MASK;
      if (adr_i == `UART_LCR_ADR)
        lcr <= d_i;
      if (adr_i == `UART_MCR_ADR)
        mcr <= d_i & `UART_LOW_NIBBLE_MASK;
      if (adr_i == `UART_SCR_ADR)
        scr <= d_i;
    end
  end

  // Divisor latch, DLL at 0 and DLM at 1 with DLAB set
  always_ff @(posedge clk_i)
  begin
    if (we_i && dlab && adr_i == `UART_RBR_ADR)
      dll <= d_i;
    if (we_i && dlab && adr_i == `UART_IER_ADR)
      dlm <= d_i;
  end

  assign divisor_o = {dlm, dll};

  // Counter reload one cycle after either divisor byte lands
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      div_load_o <= 1'b0;
    else
      div_load_o <= we_i & dlab & (adr_i == `UART_RBR_ADR || adr_i == `UART_IER_ADR);
  end

  //////////////////////////////
  // Read data and strobes
  //////////////////////////////

  // Registered read mux, IIR not implemented
  always_ff @(posedge clk_i)
  begin
    case (adr_i)
      `UART_RBR_ADR: q_o <= dlab ? dll : rx_d_i;
      `UART_IER_ADR: q_o <= dlab ? dlm : ier;
      `UART_IIR_ADR: q_o <= '0;
      `UART_LCR_ADR: q_o <= lcr;
      `UART_MCR_ADR: q_o <= mcr;
      `UART_LSR_ADR: q_o <= lsr_i;
      `UART_MSR_ADR: q_o <= msr_i;
      `UART_SCR_ADR: q_o <= scr;
    endcase
  end

  // THR push and RBR pop only in data mode
  assign tx_push_o  = we_i & ~dlab & (adr_i == `UART_RBR_ADR);
  assign rx_pop_o   = re_i & ~dlab & (adr_i == `UART_RBR_ADR);
  // Clear-on-read for the sticky status flags
  assign lsr_read_o = re_i & (adr_i == `UART_LSR_ADR);
  assign msr_read_o = re_i & (adr_i == `UART_MSR_ADR);

  //////////////////////////////
  // Modem control and interrupt
  //////////////////////////////

  assign mcr_ctl_o = mcr[3:0];
  assign loop_en_o = mcr[`UART_MCR_LOOP_BIT];

  // Active low modem outputs
  assign dtr_no  = ~mcr[0];
  assign rts_no  = ~mcr[1];
  assign out1_no = ~mcr[2];
  assign out2_no = ~mcr[3];

  // Modem, line status, THR empty and receive data sources
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      irq_o <= 1'b0;
    else
      irq_o <= (ier[3] & |msr_i[3:0]) |
               (ier[2] & |lsr_i[4:1]) |
               (ier[1] &  lsr_i[5])   |
               (ier[0] &  lsr_i[0]);
  end

  // Host sees IER and MCR with a clear upper nibble
  a_low_nibble: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((adr_i == `UART_IER_ADR && !dlab) || adr_i == `UART_MCR_ADR) |=> q_o[7:4] == 4'h0);

  // THR pushes never disturb the divisor latch
  a_push_keeps_div: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_push_o |=> $stable(divisor_o));

endmodule

// File: verilog/uart_baud_gen.sv
/*
 * UART baud rate generator
 * One-cycle 16x enable every divisor + 1 clocks
 */
module uart_baud_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  uart_regs_pkg::divisor_t  divisor_i,
  input  logic                     div_load_i,
  output logic                     baudout_o
);

  import uart_regs_pkg::*;

  divisor_t cnt;

  // Down counter, reload on new divisor or terminal count
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '0;
    else if (div_load_i || cnt == '0)
      cnt <= divisor_i;
    else
      cnt <= cnt - 1'b1;
  end

  // Pulse at terminal count, silent with zero divisor
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      baudout_o <= 1'b0;
    else
      baudout_o <= (cnt == '0) && (divisor_i != '0);
  end

  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (baudout_o && divisor_i > 1) |=> !baudout_o);

endmodule

// File: verilog/uart_modem_status.sv
/*
 * UART modem status encoder
 * Builds MSR from the modem pins or, in loopback, from MCR,
 * with delta flags held until an MSR read
 */
module uart_modem_status (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cts_ni,
  input  logic                     dsr_ni,
  input  logic                     dcd_ni,
  input  logic                     ri_ni,
  input  uart_regs_pkg::mcr_ctl_t  mcr_ctl_i,
  input  logic                     loop_en_i,
  input  logic                     msr_read_i,
  output uart_regs_pkg::data_t     msr_o
);

  // Delayed pins, inactive high out of reset
  logic cts_d;
  logic dsr_d;
  logic dcd_d;
  logic ri_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cts_d <= 1'b1;
      dsr_d <= 1'b1;
      dcd_d <= 1'b1;
      ri_d  <= 1'b1;
    end
    else
    begin
      cts_d <= cts_ni;
      dsr_d <= dsr_ni;
      dcd_d <= dcd_ni;
      ri_d  <= ri_ni;
    end
  end

  //////////////////////////////
  // MSR encode
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      msr_o <= '0;
    else
    begin
      // Loopback maps OUT2, OUT1, DTR, RTS onto DCD, RI, DSR, CTS
      msr_o[7] <= loop_en_i ? mcr_ctl_i[3] : ~dcd_ni;
      msr_o[6] <= loop_en_i ? mcr_ctl_i[2] : ~ri_ni;
      msr_o[5] <= loop_en_i ? mcr_ctl_i[0] : ~dsr_ni;
      msr_o[4] <= loop_en_i ? mcr_ctl_i[1] : ~cts_ni;
      // Any change on DCD, DSR, CTS
      msr_o[3] <= (dcd_ni ^ dcd_d) | (msr_o[3] & ~msr_read_i);
      msr_o[1] <= (dsr_ni ^ dsr_d) | (msr_o[1] & ~msr_read_i);
      msr_o[0] <= (cts_ni ^ cts_d) | (msr_o[0] & ~msr_read_i);
      // Trailing edge of RI, pin going high
      msr_o[2] <= (ri_ni & ~ri_d) | (msr_o[2] & ~msr_read_i);
    end
  end

endmodule

// File: verilog/uart_line_status.sv
/*
 * UART line status encoder
 * Builds LSR from FIFO flags, with sticky receive error bits
 */
`include "uart_regs_cfg.svh"

module uart_line_status (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rx_empty_i,
  input  logic                  rx_pe_i,
  input  logic                  rx_fe_i,
  input  logic                  rx_bi_i,
  input  logic                  overrun_error_i,
  input  logic                  tx_empty_i,
  input  logic                  tx_sr_empty_i,
  input  logic                  lsr_read_i,
  output uart_regs_pkg::data_t  lsr_o
);

  // Previous error levels for edge detection
  logic oe_d;
  logic pe_d;
  logic fe_d;
  logic bi_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      oe_d <= 1'b0;
      pe_d <= 1'b0;
      fe_d <= 1'b0;
      bi_d <= 1'b0;
    end
    else
    begin
      oe_d <= overrun_error_i;
      pe_d <= rx_pe_i;
      fe_d <= rx_fe_i;
      bi_d <= rx_bi_i;
    end
  end

  // Errors set on rising edge, held until LSR read
  // Bit 7 is the FIFO error flag, not implemented
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lsr_o <= `UART_LSR_RST;
    else
    begin
      lsr_o[0] <= ~rx_empty_i;
      lsr_o[1] <= (overrun_error_i & ~oe_d) | (lsr_o[1] & ~lsr_read_i);
      lsr_o[2] <= (rx_pe_i & ~pe_d) | (lsr_o[2] & ~lsr_read_i);
      lsr_o[3] <= (rx_fe_i & ~fe_d) | (lsr_o[3] & ~lsr_read_i);
      lsr_o[4] <= (rx_bi_i & ~bi_d) | (lsr_o[4] & ~lsr_read_i);
      lsr_o[5] <= tx_empty_i;
      lsr_o[6] <= tx_empty_i & tx_sr_empty_i;
      lsr_o[7] <= 1'b0;
    end
  end

  // Sticky errors only drop after an LSR read
  a_sticky_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|($past(lsr_o[4:1]) & ~lsr_o[4:1])) |-> $past(lsr_read_i));

endmodule

// File: verilog/uart_regs_pkg.sv
/*
 * UART register block types
 * Vector types for addresses, register bytes, divisor and modem control
 */
`include "uart_regs_cfg.svh"

package uart_regs_pkg;

  //////////////////////////////
  // Host bus
  //////////////////////////////

  // Register select on the host bus
  typedef logic [`UART_ADR_W-1:0]  adr_t;

  // One register byte, read or write data
  typedef logic [`UART_DATA_W-1:0] data_t;

  //////////////////////////////
  // Baud generation
  //////////////////////////////

  // DLM:DLL concatenated
  typedef logic [`UART_DIV_W-1:0]  divisor_t;

  //////////////////////////////
  // Modem control
  //////////////////////////////

  // MCR bits 3:0
  // [0] DTR, [1] RTS, [2] OUT1, [3] OUT2
  typedef logic [3:0]              mcr_ctl_t;

endpackage

// File: verilog/uart_regs_cfg.svh
/*
 * UART register block configuration
 * Widths, 16550 register addresses, write masks and reset values
 */
`ifndef UART_REGS_CFG_SVH
`define UART_REGS_CFG_SVH

// Bus and register widths
`define UART_ADR_W            3
`define UART_DATA_W           8
`define UART_DIV_W            16

// Host register map, one word per address
`define UART_RBR_ADR          3'd0
`define UART_IER_ADR          3'd1
`define UART_IIR_ADR          3'd2
`define UART_LCR_ADR          3'd3
`define UART_MCR_ADR          3'd4
`define UART_LSR_ADR          3'd5
`define UART_MSR_ADR          3'd6
`define UART_SCR_ADR          3'd7

// IER and MCR only implement bits 3:0
`define UART_LOW_NIBBLE_MASK  8'h0F

// THRE and TEMT set out of reset
`define UART_LSR_RST          8'h60

// Control bit positions
`define UART_LCR_DLAB_BIT     7
`define UART_MCR_LOOP_BIT     4

`endif
